// File: design/structures.sv
package structures;

    // ------------------------------------------------------------------------
    // Widths and constants
    // ------------------------------------------------------------------------
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC = '0;

    // Major opcodes of the supported subset.
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA/SRAI.

    // ------------------------------------------------------------------------
    // Instruction names and bundles
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        ILLEGAL,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } instr_name_t;

    typedef struct packed {
        instr_name_t instr_name;
        word_t       immediate;  // Sign-extended.
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;         // Zero when nothing is written.
    } decoded_t;

    typedef struct packed {
        instr_name_t instr_name;
        word_t       address;
        word_t       immediate;
        word_t       data_1;
        word_t       data_2;
        reg_idx_t    rd;
    } feed_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

// File: design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import structures::*; (
    input  word_t    instr,
    output decoded_t decoded
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       imm_i;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;
    word_t       imm_sel;
    instr_name_t name;
    logic        writes_rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ------------------------------------------------------------------------
    // Immediate formats
    // ------------------------------------------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: imm_sel = imm_u;
            OP_JAL:           imm_sel = imm_j;
            OP_BRANCH:        imm_sel = imm_b;
            default:          imm_sel = imm_i; // JALR and OP-IMM.
        endcase
    end

    // ------------------------------------------------------------------------
    // Instruction name
    // ------------------------------------------------------------------------
    always_comb begin
        name = ILLEGAL;
        case (opcode)
            OP_LUI:   name = LUI;
            OP_AUIPC: name = AUIPC;
            OP_JAL:   name = JAL;
            OP_JALR:  name = (funct3 == 3'b000) ? JALR : ILLEGAL;
            OP_BRANCH: begin
                case (funct3)
                    3'b000:  name = BEQ;
                    3'b001:  name = BNE;
                    3'b100:  name = BLT;
                    3'b101:  name = BGE;
                    3'b110:  name = BLTU;
                    3'b111:  name = BGEU;
                    default: name = ILLEGAL;
                endcase
            end
            OP_IMM: begin
                case (funct3)
                    3'b000: name = ADDI;
                    3'b010: name = SLTI;
                    3'b011: name = SLTIU;
                    3'b100: name = XORI;
                    3'b110: name = ORI;
                    3'b111: name = ANDI;
                    3'b001: name = (funct7 == F7_BASE) ? SLLI : ILLEGAL;
                    3'b101: begin
                        if (funct7 == F7_BASE)
                            name = SRLI;
                        else if (funct7 == F7_ALT)
                            name = SRAI;
                    end
                endcase
            end
            OP_REG: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000: name = ADD;
                        3'b001: name = SLL;
                        3'b010: name = SLT;
                        3'b011: name = SLTU;
                        3'b100: name = XOR;
                        3'b101: name = SRL;
                        3'b110: name = OR;
                        3'b111: name = AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == 3'b000)
                        name = SUB;
                    else if (funct3 == 3'b101)
                        name = SRA;
                end
            end
            default: name = ILLEGAL;
        endcase
    end

    assign writes_rd = !(name inside {ILLEGAL, BEQ, BNE, BLT, BGE, BLTU, BGEU});

    assign decoded.instr_name = name;
    assign decoded.immediate  = imm_sel;
    assign decoded.rs1        = instr[19:15];
    assign decoded.rs2        = instr[24:20];
    assign decoded.rd         = writes_rd ? instr[11:7] : '0;

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file import structures::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    data_1,
    output word_t    data_2,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata; // x0 is never written.
        end
    end

    // Combinational reads with x0 forced to zero.
    assign data_1 = (rs1 == '0) ? '0 : regs[rs1];
    assign data_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu import structures::*; (
    input  feed_t feed,
    output word_t result
);

    logic       is_imm;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    assign is_imm = feed.instr_name inside {ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
                                            SLLI, SRLI, SRAI};

    assign op_a  = feed.data_1;
    assign op_b  = is_imm ? feed.immediate : feed.data_2;
    assign shamt = op_b[4:0]; // Low five bits only.

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------
    always_comb begin
        case (feed.instr_name)
            LUI:         result = feed.immediate;
            AUIPC:       result = feed.address + feed.immediate;
            ADD, ADDI:   result = op_a + op_b;
            SUB:         result = op_a - op_b;
            SLT, SLTI:   result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            SLTU, SLTIU: result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
            XOR, XORI:   result = op_a ^ op_b;
            OR, ORI:     result = op_a | op_b;
            AND, ANDI:   result = op_a & op_b;
            SLL, SLLI:   result = op_a << shamt;
            SRL, SRLI:   result = op_a >> shamt;
            SRA, SRAI:   result = $signed(op_a) >>> shamt; // Sign fill.
            default:     result = '0; // Jumps, branches, illegal.
        endcase
    end

endmodule

// File: design/branch.sv
`timescale 1ns/1ps

module branch import structures::*; (
    input  feed_t feed,
    output word_t jump_result,
    output word_t store_result
);

    word_t seq_pc;
    word_t target_pc;

    assign seq_pc    = feed.address + XLEN'(4);
    assign target_pc = feed.address + feed.immediate;

    // ------------------------------------------------------------------------
    // Next pc and link
    // ------------------------------------------------------------------------
    always_comb begin
        jump_result  = seq_pc;
        store_result = '0;
        case (feed.instr_name)
            JAL: begin
                jump_result  = target_pc;
                store_result = seq_pc;
            end
            JALR: begin
                // Bit zero of the target is kept as computed.
                jump_result  = feed.data_1 + feed.immediate;
                store_result = seq_pc;
            end
            BEQ: begin
                if (feed.data_1 == feed.data_2)
                    jump_result = target_pc;
            end
            BNE: begin
                if (feed.data_1 != feed.data_2)
                    jump_result = target_pc;
            end
            BLT: begin
                if ($signed(feed.data_1) < $signed(feed.data_2))
                    jump_result = target_pc;
            end
            BGE: begin
                if ($signed(feed.data_1) >= $signed(feed.data_2))
                    jump_result = target_pc;
            end
            BLTU: begin
                if (feed.data_1 < feed.data_2)
                    jump_result = target_pc;
            end
            BGEU: begin
                if (feed.data_1 >= feed.data_2)
                    jump_result = target_pc;
            end
            default: jump_result = seq_pc; // Everything else falls through.
        endcase
    end

endmodule

// File: design/exec_core.sv
`timescale 1ns/1ps

module exec_core import structures::*; (
    input  logic    clk,
    input  logic    reset,
    input  word_t   instr,
    input  logic    instr_valid,
    output word_t   pc,
    output logic    retire_valid,
    output retire_t retire,
    output logic    illegal
);

    decoded_t decoded;
    feed_t    feed;
    word_t    data_1;
    word_t    data_2;
    word_t    alu_result;
    word_t    next_pc;
    word_t    link;
    word_t    wb_data;

    instr_decoder decoder_i (
        .instr   (instr),
        .decoded (decoded)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .reset  (reset),
        .rs1    (decoded.rs1),
        .rs2    (decoded.rs2),
        .data_1 (data_1),
        .data_2 (data_2),
        .we     (instr_valid),  // rd is already zero for non-writers.
        .rd     (feed.rd),
        .wdata  (wb_data)
    );

    assign feed = '{instr_name: decoded.instr_name,
                    address:    pc,
                    immediate:  decoded.immediate,
                    data_1:     data_1,
                    data_2:     data_2,
                    rd:         decoded.rd};

    alu alu_i (
        .feed   (feed),
        .result (alu_result)
    );

    branch branch_i (
        .feed         (feed),
        .jump_result  (next_pc),
        .store_result (link)
    );

    assign wb_data = (feed.instr_name inside {JAL, JALR}) ? link : alu_result;

    // ------------------------------------------------------------------------
    // Program counter and retire
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= RESET_PC;
            retire_valid <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire_valid <= instr_valid;
            illegal      <= instr_valid && (feed.instr_name == ILLEGAL);
            if (instr_valid)
                pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid)
            retire <= '{rd: feed.rd, data: wb_data}; // Qualified by retire_valid.
    end

endmodule

// File: verif/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb import structures::*; ();

    localparam int NUM_INSTR      = 2000;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTR + 490; // Slack for the tail.

    typedef struct packed {
        word_t    pc;
        logic     retire_valid;
        logic     illegal;
        logic     writes;
        reg_idx_t rd;
        word_t    data;
    } expect_t;

    logic    clk;
    logic    reset;
    word_t   instr;
    logic    instr_valid;
    word_t   pc;
    logic    retire_valid;
    retire_t retire;
    logic    illegal;

    word_t   model_regs [NUM_REGS];
    word_t   model_pc;
    expect_t pred;     // Outputs after the coming edge.
    expect_t exp_out;  // Outputs after the last edge.
    integer  seed = 44453;
    int      cycle_count;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    exec_core dut_i (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire),
        .illegal      (illegal)
    );

    always @(posedge clk) begin
        exp_out <= pred;
    end

    task automatic end_with_failure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        end_with_failure();
    endtask

    // ------------------------------------------------------------------------
    // Checks on the registered outputs
    // ------------------------------------------------------------------------
    check_pc: assert property (@(posedge clk) disable iff (reset) pc == exp_out.pc)
        else report_mismatch($sformatf("pc %h, expected %h", $sampled(pc),
                                       $sampled(exp_out.pc)));
    check_valid: assert property (@(posedge clk) disable iff (reset)
                                  retire_valid == exp_out.retire_valid)
        else report_mismatch("retire_valid differs from the model");
    check_illegal: assert property (@(posedge clk) disable iff (reset)
                                    illegal == exp_out.illegal)
        else report_mismatch("illegal differs from the model");
    check_rd: assert property (@(posedge clk) disable iff (reset)
                               retire_valid |-> retire.rd == exp_out.rd)
        else report_mismatch($sformatf("retire rd %0d, expected %0d", $sampled(retire.rd),
                                       $sampled(exp_out.rd)));
    check_data: assert property (@(posedge clk) disable iff (reset)
                                 retire_valid && exp_out.writes |-> retire.data == exp_out.data)
        else report_mismatch($sformatf("retire data %h, expected %h", $sampled(retire.data),
                                       $sampled(exp_out.data)));

    // ------------------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------------------
    function automatic logic [2:0] funct3_of(instr_name_t name);
        case (name)
            BNE, SLLI, SLL:            return 3'b001;
            SLTI, SLT:                 return 3'b010;
            SLTIU, SLTU:               return 3'b011;
            BLT, XORI, XOR:            return 3'b100;
            BGE, SRLI, SRAI, SRL, SRA: return 3'b101;
            BLTU, ORI, OR:             return 3'b110;
            BGEU, ANDI, AND:           return 3'b111;
            default:                   return 3'b000; // BEQ, JALR, ADD, ADDI, SUB.
        endcase
    endfunction

    function automatic word_t format_immediate(instr_name_t name, word_t r);
        case (name)
            LUI, AUIPC:                     return {r[31:12], 12'b0};
            JAL:                            return {{11{r[20]}}, r[20:1], 1'b0};
            BEQ, BNE, BLT, BGE, BLTU, BGEU: return {{19{r[12]}}, r[12:1], 1'b0};
            SLLI, SRLI, SRAI:               return {27'b0, r[4:0]};
            default:                        return {{20{r[11]}}, r[11:0]};
        endcase
    endfunction

    function automatic word_t encode(instr_name_t name, reg_idx_t rd, reg_idx_t rs1,
                                     reg_idx_t rs2, word_t imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = funct3_of(name);
        f7 = (name inside {SUB, SRA, SRAI}) ? F7_ALT : F7_BASE;
        case (name)
            LUI:   return {imm[31:12], rd, OP_LUI};
            AUIPC: return {imm[31:12], rd, OP_AUIPC};
            JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
            JALR:  return {imm[11:0], rs1, f3, rd, OP_JALR};
            BEQ, BNE, BLT, BGE, BLTU, BGEU:
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
            SLLI, SRLI, SRAI: return {f7, imm[4:0], rs1, f3, rd, OP_IMM};
            ADDI, SLTI, SLTIU, XORI, ORI, ANDI: return {imm[11:0], rs1, f3, rd, OP_IMM};
            ILLEGAL: return {imm[24:0], 7'b0000011}; // Load opcode.
            default: return {f7, rs2, rs1, f3, rd, OP_REG};
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic step_model(input logic valid, input instr_name_t name, input reg_idx_t rd,
                              input reg_idx_t rs1, input reg_idx_t rs2, input word_t imm);
        word_t a;
        word_t b;
        word_t res;
        logic  taken;
        logic  writes;
        a      = model_regs[rs1];
        b      = (name inside {ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI}) ?
                 imm : model_regs[rs2];
        res    = '0;
        taken  = 1'b0;
        writes = !(name inside {ILLEGAL, BEQ, BNE, BLT, BGE, BLTU, BGEU});
        case (name)
            LUI:         res = imm;
            AUIPC:       res = model_pc + imm;
            JAL, JALR:   res = model_pc + 4;
            BEQ:         taken = (a == b);
            BNE:         taken = (a != b);
            BLT:         taken = ($signed(a) < $signed(b));
            BGE:         taken = ($signed(a) >= $signed(b));
            BLTU:        taken = (a < b);
            BGEU:        taken = (a >= b);
            ADD, ADDI:   res = a + b;
            SUB:         res = a - b;
            SLT, SLTI:   res = word_t'($signed(a) < $signed(b));
            SLTU, SLTIU: res = word_t'(a < b);
            XOR, XORI:   res = a ^ b;
            OR, ORI:     res = a | b;
            AND, ANDI:   res = a & b;
            SLL, SLLI:   res = a << b[4:0];
            SRL, SRLI:   res = a >> b[4:0];
            SRA, SRAI:   res = $signed(a) >>> b[4:0];
            default:     res = '0;
        endcase
        pred.retire_valid = valid;
        pred.illegal      = valid && (name == ILLEGAL);
        pred.writes       = writes;
        pred.rd           = writes ? rd : '0;
        pred.data         = res;
        if (valid) begin
            if (name == JALR)
                model_pc = a + imm; // Target bit zero not cleared.
            else if (name == JAL || taken)
                model_pc = model_pc + imm;
            else
                model_pc = model_pc + 4;
            if (writes && rd != '0)
                model_regs[rd] = res;
        end
        pred.pc = model_pc;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
        end_with_failure();
    end

    initial begin
        instr_name_t name;
        integer      pick;
        integer      sel;
        word_t       r;
        word_t       imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic        valid;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        model_pc    = RESET_PC;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        pred = '{pc: RESET_PC, default: '0};
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            pick  = $random(seed);
            sel   = $random(seed);
            r     = $random(seed);
            valid = (pick[3:0] != 4'd0); // Idle about one cycle in 16.
            name  = (pick[8:4] == 5'd0) ? ILLEGAL :
                    instr_name_t'(5'd1 + 5'(pick[19:9] % 29));
            rd    = pick[20] ? pick[25:21] : {2'b00, pick[23:21]};
            rs1   = sel[5] ? sel[4:0] : {2'b00, sel[2:0]};
            rs2   = sel[11] ? sel[10:6] : {2'b00, sel[8:6]};
            imm   = format_immediate(name, r);
            instr       = encode(name, rd, rs1, rs2, imm);
            instr_valid = valid;
            step_model(valid, name, rd, rs1, rs2, imm);
            @(posedge clk);
            #2;
        end
        instr_valid = 1'b0;
        step_model(1'b0, ILLEGAL, '0, '0, '0, '0);
        repeat (2) @(posedge clk);
        #2;
        $display("** PASS **");
        $finish;
    end

endmodule

// File: exec_core.f
design/structures.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/branch.sv
design/exec_core.sv
verif/exec_core_tb.sv
